// File: bench/commu_golden.txt
# op name addr data, numbers in hex, page 2a is the DUT's own
# W write, R read and compare, F frame for device data, S tx_ready mode (0 low, 1 random)
R rd_mod_id      2a00 2a
R rd_num_dev     2a10 14
R rd_send_en     2a14 01
R rd_dbg0        2a80 80
R rd_dbg7        2a87 87
R rd_unmapped    2a40 00
R rd_foreign     1510 00
W wr_foreign     1510 03
R num_dev_kept   2a10 14
W wr_dbg3        2a83 3c
R rd_dbg3        2a83 3c
R fcnt_start     2a20 00
S rdy_random     0000 01
F frame_dev0     0000 00
F frame_dev1     0000 01
W wr_num_dev     2a10 03
F frame_dev2     0000 02
F frame_dev3     0000 03
F frame_wrap0    0000 00
F frame_wrap1    0000 01
R fcnt_six       2a20 06
W send_en_off    2a14 00
S rdy_low        0000 00
W retry_5        2a30 05
W retry_7        2a30 07
S rdy_release    0000 01
F frame_held2    0000 02
F frame_held0    0000 00
F frame_retry7   0000 07
R fcnt_nine      2a20 09

// File: bench/commu_tb.sv
// commu controller testbench
`timescale 1ns/1ps

module commu_tb;

	localparam logic [5:0] OWN_ID     = 6'h2a;
	localparam logic [7:0] HDR        = 8'hA5;
	localparam int         NAME_W     = 8 * 24;
	localparam int         DRAIN_CYC  = 200;
	localparam int         CYC_PER_OP = 400;
	localparam string      GOLDEN     = "bench/commu_golden.txt";

	logic        clk_sys;
	logic        rst_n;
	logic        fx_wr;
	logic [15:0] fx_waddr;
	logic [7:0]  fx_data;
	logic        fx_rd;
	logic [15:0] fx_raddr;
	logic [5:0]  mod_id;
	logic        tx_ready;
	logic        tx_valid;
	logic [7:0]  tx_data;
	logic [7:0]  fx_q;

	// golden script held as parallel queues
	logic [7:0]        op_q[$];
	logic [NAME_W-1:0] name_q[$];
	logic [15:0]       addr_q[$];
	logic [7:0]        data_q[$];
	logic              loaded;

	int          errors;
	int          checks;
	logic        ready_mode;
	logic [31:0] rnd;

	// stream monitor state
	logic [23:0] frame_q[$];
	logic [23:0] cur_frame;
	int          byte_pos;
	logic        stalled;
	logic [7:0]  stall_data;

	commu_top dut (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.fx_wr    (fx_wr),
		.fx_waddr (fx_waddr),
		.fx_data  (fx_data),
		.fx_rd    (fx_rd),
		.fx_raddr (fx_raddr),
		.mod_id   (mod_id),
		.tx_ready (tx_ready),
		.tx_valid (tx_valid),
		.tx_data  (tx_data),
		.fx_q     (fx_q)
	);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] next_rand(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_eq(input logic [NAME_W-1:0] name, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("error %0s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	// one ready decision per cycle
	task automatic step_ready();
		if (ready_mode) begin
			rnd = next_rand(rnd);
			tx_ready = rnd[4];
		end else begin
			tx_ready = 1'b0;
		end
		@(posedge clk_sys);
		#1;
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		fx_wr    = 1'b1;
		fx_waddr = addr;
		fx_data  = data;
		@(posedge clk_sys);
		#1;
		fx_wr = 1'b0;
	endtask

	task automatic bus_read(input logic [NAME_W-1:0] name, input logic [15:0] addr,
			input logic [7:0] exp);
		fx_rd    = 1'b1;
		fx_raddr = addr;
		// bus still idle before the read edge
		@(negedge clk_sys);
		check_eq(name, 32'h0, {24'h0, fx_q});
		@(posedge clk_sys);
		#1;
		fx_rd = 1'b0;
		// value registered at the edge just passed
		@(negedge clk_sys);
		check_eq(name, {24'h0, exp}, {24'h0, fx_q});
		@(posedge clk_sys);
		#1;
	endtask

	// stream only moves while a frame is awaited
	task automatic await_frame(input logic [NAME_W-1:0] name, input logic [7:0] dev);
		logic [23:0] got;
		while (frame_q.size() == 0) begin
			step_ready();
		end
		tx_ready = 1'b0;
		got = frame_q.pop_front();
		check_eq(name, {8'h0, HDR, dev, HDR ^ dev}, {8'h0, got});
	endtask

	task automatic load_golden();
		int                fd;
		int                r;
		logic [NAME_W-1:0] tok;
		logic [NAME_W-1:0] nm;
		logic [15:0]       a;
		logic [7:0]        d;
		logic [8*128-1:0]  rest;
		fd = $fopen(GOLDEN, "r");
		if (fd == 0) begin
			errors++;
			$display("could not open golden file %0s", GOLDEN);
		end else begin
			while (!$feof(fd)) begin
				r = $fscanf(fd, "%s", tok);
				if (r == 1 && tok == "#") begin
					r = $fgets(rest, fd);
				end else if (r == 1) begin
					r = $fscanf(fd, "%s %h %h", nm, a, d);
					if (r != 3) begin
						errors++;
						$display("golden line for %0s is missing fields", nm);
					end
					op_q.push_back(tok[7:0]);
					name_q.push_back(nm);
					addr_q.push_back(a);
					data_q.push_back(d);
				end
			end
			$fclose(fd);
		end
		loaded = 1'b1;
	endtask

	// ------------------------------------------------------------
	// stream monitor sampled mid-cycle
	// ------------------------------------------------------------
	always @(negedge clk_sys) begin
		if (rst_n) begin
			if (stalled && tx_valid) begin
				check_eq("tx_hold", {24'h0, stall_data}, {24'h0, tx_data});
			end
			stalled    = tx_valid && !tx_ready;
			stall_data = tx_data;
			if (tx_valid && tx_ready) begin
				cur_frame = {cur_frame[15:0], tx_data};
				byte_pos++;
				if (byte_pos == 3) begin
					frame_q.push_back(cur_frame);
					byte_pos = 0;
				end
			end
		end
	end

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		rst_n      = 1'b0;
		fx_wr      = 1'b0;
		fx_rd      = 1'b0;
		fx_waddr   = '0;
		fx_raddr   = '0;
		fx_data    = '0;
		mod_id     = OWN_ID;
		tx_ready   = 1'b0;
		errors     = 0;
		checks     = 0;
		ready_mode = 1'b0;
		rnd        = 32'hf7fe;
		loaded     = 1'b0;
		cur_frame  = '0;
		byte_pos   = 0;
		stalled    = 1'b0;
		stall_data = '0;
		load_golden();
		repeat (16) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		for (int i = 0; i < op_q.size(); i++) begin
			case (op_q[i])
				"W": bus_write(addr_q[i], data_q[i]);
				"R": bus_read(name_q[i], addr_q[i], data_q[i]);
				"F": await_frame(name_q[i], data_q[i]);
				"S": ready_mode = data_q[i][0];
				default: begin
					errors++;
					$display("unknown opcode %0s in golden entry %0d", op_q[i], i);
				end
			endcase
		end
		// free-running stream with no frame left to come
		repeat (DRAIN_CYC) step_ready();
		tx_ready = 1'b0;
		while (frame_q.size() != 0) begin
			errors++;
			$display("frame %0h arrived after the last expected one", frame_q.pop_front());
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// limit grows with the script length
	initial begin
		wait (loaded);
		repeat ((op_q.size() + 1) * CYC_PER_OP) @(posedge clk_sys);
		$display("timeout, golden script did not complete in %0d cycles",
			(op_q.size() + 1) * CYC_PER_OP);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: compile.f
src/commu_pkg.sv
src/commu_reg.sv
src/poll_sched.sv
src/tx_framer.sv
src/commu_top.sv
bench/commu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the commu testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module commu_tb -f compile.f -o commu_sim
out=$(./obj_dir/commu_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Simulation finished: PASS"

// File: src/commu_pkg.sv
// commu controller constants
package commu_pkg;

	// ------------------------------------------------------------
	// fx bus geometry
	// ------------------------------------------------------------
	localparam int FX_DW   = 8;
	localparam int FX_AW   = 16;
	localparam int MOD_IDW = 6;

	// offset field in address bits 7:0, page id just above it
	localparam int OFS_W    = 8;
	localparam int PAGE_LSB = OFS_W;

	// device index, shared by all three blocks
	localparam int DEV_W = 8;

	// ------------------------------------------------------------
	// register map
	// ------------------------------------------------------------
	localparam logic [OFS_W-1:0] REG_MOD_ID    = 8'h00;
	localparam logic [OFS_W-1:0] REG_NUM_DEV   = 8'h10;
	localparam logic [OFS_W-1:0] REG_SEND_EN   = 8'h14;
	localparam logic [OFS_W-1:0] REG_FRAME_CNT = 8'h20;
	localparam logic [OFS_W-1:0] REG_RETRY     = 8'h30;
	localparam logic [OFS_W-1:0] REG_DBG_BASE  = 8'h80;

	// scratch debug bank, 0x80..0x87
	localparam int DBG_NUM   = 8;
	localparam int DBG_IDX_W = $clog2(DBG_NUM);

	// ------------------------------------------------------------
	// reset values
	// ------------------------------------------------------------
	localparam logic [DEV_W-1:0] NUM_DEV_RST  = 8'd20;
	localparam logic [DEV_W-1:0] SEND_EN_RST  = 8'd1;
	// debug reg k comes up as base + k
	localparam logic [FX_DW-1:0] DBG_RST_BASE = 8'h80;

	// ------------------------------------------------------------
	// poll frame
	// ------------------------------------------------------------
	// header, device index, header xor index
	localparam logic [FX_DW-1:0] FRAME_HDR = 8'hA5;
	localparam int FRAME_LEN   = 3;
	localparam int FRAME_POS_W = $clog2(FRAME_LEN);

endpackage

// File: src/commu_reg.sv
// fx bus register slave
`timescale 1ns/1ps

module commu_reg (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          fx_wr,
	input  logic                          fx_rd,
	input  logic [commu_pkg::FX_AW-1:0]   fx_waddr,
	input  logic [commu_pkg::FX_AW-1:0]   fx_raddr,
	input  logic [commu_pkg::FX_DW-1:0]   fx_data,
	input  logic [commu_pkg::MOD_IDW-1:0] mod_id,
	input  logic [commu_pkg::DEV_W-1:0]   frame_cnt,
	output logic [commu_pkg::FX_DW-1:0]   fx_q,
	output logic [commu_pkg::DEV_W-1:0]   cfg_send_en,
	output logic [commu_pkg::DEV_W-1:0]   cfg_num_dev,
	output logic [commu_pkg::DEV_W-1:0]   cmd_retry
);

	import commu_pkg::*;

	// ------------------------------------------------------------
	// page decode
	// ------------------------------------------------------------
	logic             wr_hit;
	logic             rd_hit;
	logic [OFS_W-1:0] wr_ofs;
	logic [OFS_W-1:0] rd_ofs;
	logic             wr_dbg;
	logic             rd_dbg;

	// write and read pages are decoded independently
	assign wr_hit = fx_wr && (fx_waddr[PAGE_LSB +: MOD_IDW] == mod_id);
	assign rd_hit = fx_rd && (fx_raddr[PAGE_LSB +: MOD_IDW] == mod_id);
	assign wr_ofs = fx_waddr[OFS_W-1:0];
	assign rd_ofs = fx_raddr[OFS_W-1:0];

	// debug bank occupies one aligned block of DBG_NUM offsets
	assign wr_dbg = (wr_ofs[OFS_W-1:DBG_IDX_W] == REG_DBG_BASE[OFS_W-1:DBG_IDX_W]);
	assign rd_dbg = (rd_ofs[OFS_W-1:DBG_IDX_W] == REG_DBG_BASE[OFS_W-1:DBG_IDX_W]);

	// ------------------------------------------------------------
	// configuration and debug registers
	// ------------------------------------------------------------
	logic [FX_DW-1:0] dbg_q [DBG_NUM];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg_num_dev <= NUM_DEV_RST;
			cfg_send_en <= SEND_EN_RST;
			for (int k = 0; k < DBG_NUM; k++) begin
				dbg_q[k] <= DBG_RST_BASE + FX_DW'(k);
			end
		end else if (wr_hit) begin
			if (wr_dbg) begin
				dbg_q[wr_ofs[DBG_IDX_W-1:0]] <= fx_data;
			end else begin
				case (wr_ofs)
					REG_NUM_DEV: cfg_num_dev <= fx_data;
					REG_SEND_EN: cfg_send_en <= fx_data;
					default: ;
				endcase
			end
		end
	end

	// retry command, live only during the write cycle
	assign cmd_retry = (wr_hit && (wr_ofs == REG_RETRY)) ? fx_data : '0;

	// ------------------------------------------------------------
	// readback
	// ------------------------------------------------------------
	logic [FX_DW-1:0] rd_val;

	always_comb begin
		rd_val = '0;
		if (rd_dbg) begin
			rd_val = dbg_q[rd_ofs[DBG_IDX_W-1:0]];
		end else begin
			case (rd_ofs)
				REG_MOD_ID:    rd_val = FX_DW'(mod_id);
				REG_NUM_DEV:   rd_val = cfg_num_dev;
				REG_SEND_EN:   rd_val = cfg_send_en;
				REG_FRAME_CNT: rd_val = frame_cnt;
				// retry is write only, everything else unmapped
				default:       rd_val = '0;
			endcase
		end
	end

	// one cycle read latency, bus idles at zero
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			fx_q <= '0;
		end else if (rd_hit) begin
			fx_q <= rd_val;
		end else begin
			fx_q <= '0;
		end
	end

endmodule

// File: src/commu_top.sv
// communication controller top
`timescale 1ns/1ps

module commu_top (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          fx_wr,
	input  logic [commu_pkg::FX_AW-1:0]   fx_waddr,
	input  logic [commu_pkg::FX_DW-1:0]   fx_data,
	input  logic                          fx_rd,
	input  logic [commu_pkg::FX_AW-1:0]   fx_raddr,
	input  logic [commu_pkg::MOD_IDW-1:0] mod_id,
	input  logic                          tx_ready,
	output logic                          tx_valid,
	output logic [commu_pkg::FX_DW-1:0]   tx_data,
	output logic [commu_pkg::FX_DW-1:0]   fx_q
);

	import commu_pkg::*;

	// ------------------------------------------------------------
	// internal nets
	// ------------------------------------------------------------
	logic [DEV_W-1:0] cfg_send_en;
	logic [DEV_W-1:0] cfg_num_dev;
	logic [DEV_W-1:0] cmd_retry;
	logic [DEV_W-1:0] frame_cnt;
	logic [DEV_W-1:0] poll_dev;
	logic             poll_req;
	logic             poll_ack;

	// register slave on the fx bus
	commu_reg u_reg (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.fx_wr       (fx_wr),
		.fx_rd       (fx_rd),
		.fx_waddr    (fx_waddr),
		.fx_raddr    (fx_raddr),
		.fx_data     (fx_data),
		.mod_id      (mod_id),
		.frame_cnt   (frame_cnt),
		.fx_q        (fx_q),
		.cfg_send_en (cfg_send_en),
		.cfg_num_dev (cfg_num_dev),
		.cmd_retry   (cmd_retry)
	);

	// device polling order
	poll_sched u_sched (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.cfg_send_en (cfg_send_en),
		.cfg_num_dev (cfg_num_dev),
		.cmd_retry   (cmd_retry),
		.poll_ack    (poll_ack),
		.poll_req    (poll_req),
		.poll_dev    (poll_dev)
	);

	// frame out on the byte stream
	tx_framer u_tx (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.poll_req  (poll_req),
		.poll_dev  (poll_dev),
		.tx_ready  (tx_ready),
		.poll_ack  (poll_ack),
		.tx_valid  (tx_valid),
		.tx_data   (tx_data),
		.frame_cnt (frame_cnt)
	);

endmodule

// File: src/poll_sched.sv
// round-robin poll scheduler
`timescale 1ns/1ps

module poll_sched (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic [commu_pkg::DEV_W-1:0] cfg_send_en,
	input  logic [commu_pkg::DEV_W-1:0] cfg_num_dev,
	input  logic [commu_pkg::DEV_W-1:0] cmd_retry,
	input  logic                        poll_ack,
	output logic                        poll_req,
	output logic [commu_pkg::DEV_W-1:0] poll_dev
);

	import commu_pkg::*;

	logic             rr_en;
	logic             issue;
	logic             handshake;
	logic             req_rr;
	logic             pend_vld;
	logic [DEV_W-1:0] pend_dev;
	logic [DEV_W-1:0] rr_idx;
	logic [DEV_W:0]   rr_inc;

	// round robin only when enabled and at least one device
	assign rr_en     = cfg_send_en[0] && (cfg_num_dev != '0);
	assign issue     = !poll_req && (pend_vld || rr_en);
	assign handshake = poll_req && poll_ack;
	assign rr_inc    = {1'b0, rr_idx} + 1'b1;

	// ------------------------------------------------------------
	// pending retry slot
	// ------------------------------------------------------------
	// a new retry always wins over consumption in the same cycle
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			pend_vld <= 1'b0;
		end else if (cmd_retry != '0) begin
			pend_vld <= 1'b1;
		end else if (issue && pend_vld) begin
			pend_vld <= 1'b0;
		end
	end

	// later retry overwrites the earlier one
	always_ff @(posedge clk_sys) begin
		if (cmd_retry != '0) begin
			pend_dev <= cmd_retry;
		end
	end

	// ------------------------------------------------------------
	// request register
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			poll_req <= 1'b0;
			req_rr   <= 1'b0;
		end else if (issue) begin
			poll_req <= 1'b1;
			req_rr   <= !pend_vld;
		end else if (handshake) begin
			poll_req <= 1'b0;
		end
	end

	// retry first, otherwise current rr index
	always_ff @(posedge clk_sys) begin
		if (issue) begin
			poll_dev <= pend_vld ? pend_dev : rr_idx;
		end
	end

	// ------------------------------------------------------------
	// round-robin index
	// ------------------------------------------------------------
	// moves only on accepted rr requests; wraps also when num_dev shrank
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rr_idx <= '0;
		end else if (handshake && req_rr) begin
			if (rr_inc >= {1'b0, cfg_num_dev}) begin
				rr_idx <= '0;
			end else begin
				rr_idx <= rr_inc[DEV_W-1:0];
			end
		end
	end

endmodule

// File: src/tx_framer.sv
// poll frame transmitter
`timescale 1ns/1ps

module tx_framer (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        poll_req,
	input  logic [commu_pkg::DEV_W-1:0] poll_dev,
	input  logic                        tx_ready,
	output logic                        poll_ack,
	output logic                        tx_valid,
	output logic [commu_pkg::FX_DW-1:0] tx_data,
	output logic [commu_pkg::DEV_W-1:0] frame_cnt
);

	import commu_pkg::*;

	logic                   busy;
	logic [FRAME_POS_W-1:0] pos;
	logic [DEV_W-1:0]       dev_lat;
	logic                   accept;
	logic                   beat;
	logic                   last_beat;

	// new request taken only between frames
	assign poll_ack  = !busy;
	assign accept    = poll_req && poll_ack;
	assign beat      = tx_valid && tx_ready;
	assign last_beat = beat && (pos == FRAME_POS_W'(FRAME_LEN - 1));

	// ------------------------------------------------------------
	// byte position FSM
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			pos  <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			pos  <= '0;
		end else if (last_beat) begin
			busy <= 1'b0;
			pos  <= '0;
		end else if (beat) begin
			pos <= pos + 1'b1;
		end
	end

	// device index held for the whole frame
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			dev_lat <= poll_dev;
		end
	end

	// ------------------------------------------------------------
	// stream output
	// ------------------------------------------------------------
	assign tx_valid = busy;

	// stable while stalled since pos and dev_lat hold
	always_comb begin
		case (pos)
			FRAME_POS_W'(0): tx_data = FRAME_HDR;
			FRAME_POS_W'(1): tx_data = dev_lat;
			default:         tx_data = FRAME_HDR ^ dev_lat;
		endcase
	end

	// completed frames, wraps at 256
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			frame_cnt <= '0;
		end else if (last_beat) begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

endmodule
